//--- tb.f
+incdir+dv
verilog/mylstar_pkg.sv
verilog/mylstar_work_ram.sv
verilog/mylstar_io_regs.sv
verilog/mylstar_bus_decode.sv
verilog/mylstar_video_timing.sv
verilog/mylstar_palette.sv
verilog/mylstar_video_core.sv
dv/tb_mylstar.sv

//--- Bender.yml
package:
  name: mylstar_video_core

sources:
  - verilog/mylstar_pkg.sv
  - verilog/mylstar_work_ram.sv
  - verilog/mylstar_io_regs.sv
  - verilog/mylstar_bus_decode.sv
  - verilog/mylstar_video_timing.sv
  - verilog/mylstar_palette.sv
  - verilog/mylstar_video_core.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_mylstar.sv

//--- dv/tb_mylstar_model.svh
`ifndef TB_MYLSTAR_MODEL_SVH
`define TB_MYLSTAR_MODEL_SVH

// Shadow copies of everything the bus can write
mylstar_pkg::data_t   model_ram   [2048];
mylstar_pkg::nibble_t model_red   [16];
mylstar_pkg::nibble_t model_green [16];
mylstar_pkg::nibble_t model_blue  [16];
logic [5:0]           model_out_a = '0;
logic [4:0]           model_ctrl  = '0;
mylstar_pkg::data_t   model_out_b = '0;
logic [31:0]          rng_state   = 32'hda9b;

function automatic logic [31:0] next_random();
  rng_state ^= rng_state << 13;
  rng_state ^= rng_state >> 17;
  rng_state ^= rng_state << 5;
  return rng_state;
endfunction

function automatic logic in_window(mylstar_pkg::adr_t adr, mylstar_pkg::adr_t base, int size);
  return (adr >= base) && (adr < base + 16'(size));
endfunction

function automatic void model_write(mylstar_pkg::adr_t adr, mylstar_pkg::data_t dat);
  if (in_window(adr, mylstar_pkg::RAM_BASE, 2048)) begin
    model_ram[adr[10:0]] = dat;
  end else if (in_window(adr, mylstar_pkg::PAL_BASE, 32)) begin
    // Odd address is red, even address is green and blue
    if (adr[0]) begin
      model_red[adr[4:1]] = dat[3:0];
    end else begin
      model_green[adr[4:1]] = dat[7:4];
      model_blue[adr[4:1]]  = dat[3:0];
    end
  end else if (in_window(adr, mylstar_pkg::IO_BASE, 8)) begin
    case (adr[2:0])
      mylstar_pkg::IO_OUT_A:  model_out_a = dat[5:0];
      mylstar_pkg::IO_CTRL:   model_ctrl  = dat[4:0];
      mylstar_pkg::IO_PORT_B: model_out_b = dat;
      default:                ;
    endcase
  end
endfunction

function automatic mylstar_pkg::data_t expected_read(mylstar_pkg::adr_t adr);
  if (in_window(adr, mylstar_pkg::RAM_BASE, 2048)) begin
    return model_ram[adr[10:0]];
  end
  if (in_window(adr, mylstar_pkg::IO_BASE, 8)) begin
    case (adr[2:0])
      mylstar_pkg::IO_DIP:    return dip_switch;
      mylstar_pkg::IO_IN0:    return in0;
      mylstar_pkg::IO_PORT_B: return in1;
      default:                return 8'h00;
    endcase
  end
  // Palette and unmapped space read as zero
  return 8'h00;
endfunction

function automatic int expected_x(int cycle);
  return cycle % H_TOTAL;
endfunction

function automatic int expected_y(int cycle);
  return (cycle / H_TOTAL) % V_TOTAL;
endfunction

function automatic mylstar_pkg::nibble_t expected_nibble(mylstar_pkg::nibble_t idx,
                                                         logic blanked, int comp);
  if (blanked) begin
    return 4'h0;
  end
  case (comp)
    0:       return model_red[idx];
    1:       return model_green[idx];
    default: return model_blue[idx];
  endcase
endfunction

task automatic check_data(string name, mylstar_pkg::data_t exp, mylstar_pkg::data_t act);
  if (act !== exp) begin
    $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_nibble(string name, mylstar_pkg::nibble_t exp,
                            mylstar_pkg::nibble_t act);
  if (act !== exp) begin
    $display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_bit(string name, logic exp, logic act);
  if (act !== exp) begin
    $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
    abort_run();
  end
endtask

task automatic check_count(string name, logic [8:0] exp, logic [8:0] act);
  if (act !== exp) begin
    $display("ERR t=%0t %s expected %0d actual %0d", $time, name, exp, act);
    abort_run();
  end
endtask

`endif

//--- dv/tb_mylstar.sv
`timescale 1ns/1ns

module tb_mylstar;

  localparam int H_TOTAL         = 40;
  localparam int H_ACTIVE        = 32;
  localparam int V_TOTAL         = 20;
  localparam int V_ACTIVE        = 16;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_ACCESSES    = 200;
  localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * (3 * NUM_ACCESSES + 3 * FRAME_CYCLES);

  logic                 CLK = 1'b0;
  logic                 arst_n;
  logic                 wb_cyc, wb_stb, wb_we, wb_ack;
  mylstar_pkg::adr_t    wb_adr;
  mylstar_pkg::data_t   wb_dat_w, wb_dat_r;
  mylstar_pkg::data_t   dip_switch, in0, in1, out_b;
  logic [5:0]           out_a;
  logic [4:0]           ctrl;
  mylstar_pkg::nibble_t pixel_index;
  logic [8:0]           pix_x;
  logic [7:0]           pix_y;
  logic                 hblank, vblank, hsync, vsync;
  mylstar_pkg::data_t   red, green, blue;

  int                   video_cycle = 0;
  logic                 video_check_on = 1'b0;
  mylstar_pkg::nibble_t prev_index = '0;
  logic                 prev_hb = 1'b0;
  logic                 prev_vb = 1'b0;
  mylstar_pkg::adr_t    written[$];

  `include "tb_mylstar_model.svh"

  mylstar_video_core #(
    .H_TOTAL  (H_TOTAL),
    .H_ACTIVE (H_ACTIVE),
    .V_TOTAL  (V_TOTAL),
    .V_ACTIVE (V_ACTIVE)
  ) DUT (.*);

  always #20 CLK = ~CLK;

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopping after the first error");
  endtask

  // One Wishbone access with ack due exactly one cycle after the request
  task automatic bus_cycle(input logic we, input mylstar_pkg::adr_t adr,
                           input mylstar_pkg::data_t wdat, output mylstar_pkg::data_t rdat);
    @(posedge CLK);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdat;
    @(negedge CLK);
    check_bit("wb_ack", 1'b0, wb_ack);
    @(negedge CLK);
    check_bit("wb_ack", 1'b1, wb_ack);
    rdat = wb_dat_r;
    @(posedge CLK);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    @(negedge CLK);
    check_bit("wb_ack", 1'b0, wb_ack);
  endtask

  task automatic bus_write(mylstar_pkg::adr_t adr, mylstar_pkg::data_t dat);
    mylstar_pkg::data_t unused;
    bus_cycle(1'b1, adr, dat, unused);
    model_write(adr, dat);
  endtask

  task automatic read_and_check(mylstar_pkg::adr_t adr);
    mylstar_pkg::data_t rdat;
    bus_cycle(1'b0, adr, 8'h00, rdat);
    check_data("wb_dat_r", expected_read(adr), rdat);
  endtask

  always @(posedge CLK) begin
    pixel_index <= pix_x[3:0];
    if (arst_n) begin
      video_cycle <= video_cycle + 1;
    end
  end

  // Video outputs lag the counters by one cycle
  always @(negedge CLK) begin
    if (video_check_on) begin
      check_count("pix_x", 9'(expected_x(video_cycle)), pix_x);
      check_count("pix_y", 9'(expected_y(video_cycle)), {1'b0, pix_y});
      check_bit("hblank", prev_hb, hblank);
      check_bit("vblank", prev_vb, vblank);
      check_bit("hsync", prev_hb, hsync);
      check_bit("vsync", prev_vb, vsync);
      check_nibble("red[7:4]", expected_nibble(prev_index, prev_hb || prev_vb, 0), red[7:4]);
      check_nibble("green[7:4]", expected_nibble(prev_index, prev_hb || prev_vb, 1), green[7:4]);
      check_nibble("blue[7:4]", expected_nibble(prev_index, prev_hb || prev_vb, 2), blue[7:4]);
      check_nibble("rgb[3:0]", 4'h0, red[3:0] | green[3:0] | blue[3:0]);
    end
    prev_index = pixel_index;
    prev_hb    = expected_x(video_cycle) >= H_ACTIVE;
    prev_vb    = expected_y(video_cycle) >= V_ACTIVE;
  end

  initial begin
    mylstar_pkg::adr_t adr;
    arst_n      = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    dip_switch  = '0;
    in0         = '0;
    in1         = '0;
    pixel_index = '0;
    repeat (RESET_CYCLES - 1) @(posedge CLK);
    @(negedge CLK);
    check_bit("wb_ack", 1'b0, wb_ack);
    check_data("out_a", 8'h00, {2'b00, out_a});
    check_data("ctrl", 8'h00, {3'b000, ctrl});
    check_data("out_b", 8'h00, out_b);
    check_bit("hblank", 1'b0, hblank);
    check_bit("vblank", 1'b0, vblank);
    check_data("rgb", 8'h00, red | green | blue);
    @(posedge CLK);
    arst_n <= 1'b1;

    repeat (48) begin
      adr = mylstar_pkg::RAM_BASE + 16'(next_random() % 2048);
      bus_write(adr, 8'(next_random()));
      written.push_back(adr);
    end
    // Unmapped alias of a RAM location must not land in the RAM
    bus_write(written[0] | 16'h0800, ~expected_read(written[0]));
    read_and_check(written[0]);
    repeat (48) begin
      read_and_check(written[next_random() % written.size()]);
    end
    repeat (8) begin
      read_and_check(16'h2000 | 16'(next_random()));
      read_and_check(16'h0800 + 16'(next_random() % 2048));
    end
    read_and_check(mylstar_pkg::PAL_BASE + 16'h0003);

    repeat (4) begin
      @(posedge CLK);
      dip_switch <= 8'(next_random());
      in0        <= 8'(next_random());
      in1        <= 8'(next_random());
      for (int off = 0; off < 8; off++) begin
        read_and_check(mylstar_pkg::IO_BASE + 16'(off));
      end
      for (int off = 2; off < 5; off++) begin
        bus_write(mylstar_pkg::IO_BASE + 16'(off), 8'(next_random()));
      end
      check_data("out_a", {2'b00, model_out_a}, {2'b00, out_a});
      check_data("ctrl", {3'b000, model_ctrl}, {3'b000, ctrl});
      check_data("out_b", model_out_b, out_b);
    end

    for (int idx = 0; idx < 16; idx++) begin
      bus_write(mylstar_pkg::PAL_BASE + 16'({idx[3:0], 1'b1}), 8'(next_random()));
      bus_write(mylstar_pkg::PAL_BASE + 16'({idx[3:0], 1'b0}), 8'(next_random()));
    end
    @(posedge CLK);
    video_check_on <= 1'b1;
    repeat (2 * FRAME_CYCLES) @(posedge CLK);
    video_check_on <= 1'b0;
    @(negedge CLK);

    $display("Test completed successfully");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Timeout: the test did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    abort_run();
  end

endmodule

//--- verilog/mylstar_video_core.sv
`timescale 1ns/1ns

module mylstar_video_core #(
  parameter int H_TOTAL  = 318,
  parameter int H_ACTIVE = 256,
  parameter int V_TOTAL  = 256,
  parameter int V_ACTIVE = 240
) (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  mylstar_pkg::adr_t     wb_adr,
  input  mylstar_pkg::data_t    wb_dat_w,
  output mylstar_pkg::data_t    wb_dat_r,
  output logic                  wb_ack,
  input  mylstar_pkg::data_t    dip_switch,
  input  mylstar_pkg::data_t    in0,
  input  mylstar_pkg::data_t    in1,
  output logic [5:0]            out_a,
  output logic [4:0]            ctrl,
  output mylstar_pkg::data_t    out_b,
  input  mylstar_pkg::nibble_t  pixel_index,
  output logic [8:0]            pix_x,
  output logic [7:0]            pix_y,
  output logic                  hblank,
  output logic                  vblank,
  output logic                  hsync,
  output logic                  vsync,
  output mylstar_pkg::data_t    red,
  output mylstar_pkg::data_t    green,
  output mylstar_pkg::data_t    blue
);

  logic               ram_we;
  logic               io_we;
  logic               pal_we;
  logic [2:0]         io_offset;
  mylstar_pkg::data_t ram_rdata;
  mylstar_pkg::data_t io_rdata;
  logic               line_blank;
  logic               frame_blank;

  mylstar_bus_decode u_bus_decode (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .ram_rdata (ram_rdata),
    .io_rdata  (io_rdata),
    .wb_ack    (wb_ack),
    .wb_dat_r  (wb_dat_r),
    .ram_we    (ram_we),
    .io_we     (io_we),
    .pal_we    (pal_we),
    .io_offset (io_offset)
  );

  mylstar_work_ram u_work_ram (
    .CLK   (CLK),
    .we    (ram_we),
    .addr  (wb_adr[mylstar_pkg::RAM_ADDR_W-1:0]),
    .wdata (wb_dat_w),
    .rdata (ram_rdata)
  );

  mylstar_io_regs u_io_regs (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .we         (io_we),
    .offset     (io_offset),
    .wdata      (wb_dat_w),
    .dip_switch (dip_switch),
    .in0        (in0),
    .in1        (in1),
    .rdata      (io_rdata),
    .out_a      (out_a),
    .ctrl       (ctrl),
    .out_b      (out_b)
  );

  mylstar_video_timing #(
    .H_TOTAL  (H_TOTAL),
    .H_ACTIVE (H_ACTIVE),
    .V_TOTAL  (V_TOTAL),
    .V_ACTIVE (V_ACTIVE)
  ) u_video_timing (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .pix_x       (pix_x),
    .pix_y       (pix_y),
    .line_blank  (line_blank),
    .frame_blank (frame_blank)
  );

  // Palette entry from address bits 4..1, component select on bit 0
  mylstar_palette u_palette (
    .CLK         (CLK),
    .arst_n      (arst_n),
    .we          (pal_we),
    .windex      (wb_adr[4:1]),
    .waddr_lsb   (wb_adr[0]),
    .wdata       (wb_dat_w),
    .pixel_index (pixel_index),
    .line_blank  (line_blank),
    .frame_blank (frame_blank),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .hblank      (hblank),
    .vblank      (vblank),
    .hsync       (hsync),
    .vsync       (vsync)
  );

endmodule

//--- verilog/mylstar_palette.sv
`timescale 1ns/1ns

module mylstar_palette (
  input  logic                  CLK,
  input  logic                  arst_n,
  input  logic                  we,
  input  mylstar_pkg::nibble_t  windex,
  input  logic                  waddr_lsb,
  input  mylstar_pkg::data_t    wdata,
  input  mylstar_pkg::nibble_t  pixel_index,
  input  logic                  line_blank,
  input  logic                  frame_blank,
  output mylstar_pkg::data_t    red,
  output mylstar_pkg::data_t    green,
  output mylstar_pkg::data_t    blue,
  output logic                  hblank,
  output logic                  vblank,
  output logic                  hsync,
  output logic                  vsync
);

  mylstar_pkg::nibble_t red_mem   [16];
  mylstar_pkg::nibble_t green_mem [16];
  mylstar_pkg::nibble_t blue_mem  [16];
  mylstar_pkg::nibble_t red_q;
  mylstar_pkg::nibble_t green_q;
  mylstar_pkg::nibble_t blue_q;

  // Odd address holds red, even address holds green and blue
  always_ff @(posedge CLK) begin
    if (we && waddr_lsb) begin
      red_mem[windex] <= wdata[3:0];
    end
    if (we && !waddr_lsb) begin
      blue_mem[windex]  <= wdata[3:0];
      green_mem[windex] <= wdata[7:4];
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      red_q  <= '0;
      green_q <= '0;
      blue_q <= '0;
      hblank <= 1'b0;
      vblank <= 1'b0;
    end else begin
      hblank <= line_blank;
      vblank <= frame_blank;
      if (line_blank || frame_blank) begin
        red_q   <= '0;
        green_q <= '0;
        blue_q  <= '0;
      end else begin
        red_q   <= red_mem[pixel_index];
        green_q <= green_mem[pixel_index];
        blue_q  <= blue_mem[pixel_index];
      end
    end
  end

  // Board ties sync straight to blank
  assign hsync = hblank;
  assign vsync = vblank;

  assign red   = {red_q, 4'd0};
  assign green = {green_q, 4'd0};
  assign blue  = {blue_q, 4'd0};

  rgb_dark_in_blank: assert property (@(posedge CLK) disable iff (!arst_n)
    (hblank || vblank) |-> (red == '0 && green == '0 && blue == '0));

endmodule

//--- verilog/mylstar_video_timing.sv
`timescale 1ns/1ns

module mylstar_video_timing #(
  parameter int H_TOTAL  = 318,
  parameter int H_ACTIVE = 256,
  parameter int V_TOTAL  = 256,
  parameter int V_ACTIVE = 240
) (
  input  logic        CLK,
  input  logic        arst_n,
  output logic [8:0]  pix_x,
  output logic [7:0]  pix_y,
  output logic        line_blank,
  output logic        frame_blank
);

  localparam logic [8:0] H_LAST  = 9'(H_TOTAL - 1);
  localparam logic [8:0] H_BLANK = 9'(H_ACTIVE);
  localparam logic [7:0] V_LAST  = 8'(V_TOTAL - 1);
  localparam logic [7:0] V_BLANK = 8'(V_ACTIVE);

  logic line_end;

  assign line_end = (pix_x == H_LAST);

  // Horizontal counter loads 0 after the last count, carry steps the line
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pix_x <= '0;
      pix_y <= '0;
    end else if (line_end) begin
      pix_x <= '0;
      if (pix_y == V_LAST) begin
        pix_y <= '0;
      end else begin
        pix_y <= pix_y + 8'd1;
      end
    end else begin
      pix_x <= pix_x + 9'd1;
    end
  end

  assign line_blank  = (pix_x >= H_BLANK);
  assign frame_blank = (pix_y >= V_BLANK);

  pix_x_in_range: assert property (@(posedge CLK) disable iff (!arst_n)
    pix_x < 9'(H_TOTAL));

endmodule

//--- verilog/mylstar_bus_decode.sv
`timescale 1ns/1ns

module mylstar_bus_decode (
  input  logic                CLK,
  input  logic                arst_n,
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  mylstar_pkg::adr_t   wb_adr,
  input  mylstar_pkg::data_t  ram_rdata,
  input  mylstar_pkg::data_t  io_rdata,
  output logic                wb_ack,
  output mylstar_pkg::data_t  wb_dat_r,
  output logic                ram_we,
  output logic                io_we,
  output logic                pal_we,
  output logic [2:0]          io_offset
);

  mylstar_pkg::bus_state_e  state;
  mylstar_pkg::bus_region_e region;
  mylstar_pkg::bus_region_e region_q;
  logic                     accept;

  // Window compare on the bits above each window size
  always_comb begin
    if (wb_adr[15:mylstar_pkg::RAM_ADDR_W] ==
        mylstar_pkg::RAM_BASE[15:mylstar_pkg::RAM_ADDR_W]) begin
      region = mylstar_pkg::REG_RAM;
    end else if (wb_adr[15:5] == mylstar_pkg::PAL_BASE[15:5]) begin
      region = mylstar_pkg::REG_PALETTE;
    end else if (wb_adr[15:3] == mylstar_pkg::IO_BASE[15:3]) begin
      region = mylstar_pkg::REG_IO;
    end else begin
      region = mylstar_pkg::REG_NONE;
    end
  end

  // Stb is not looked at while ack is out
  assign accept = (state == mylstar_pkg::BUS_IDLE) && wb_cyc && wb_stb;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= mylstar_pkg::BUS_IDLE;
    end else if (accept) begin
      state <= mylstar_pkg::BUS_ACK;
    end else begin
      state <= mylstar_pkg::BUS_IDLE;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      region_q <= region;
    end
  end

  assign wb_ack    = (state == mylstar_pkg::BUS_ACK);
  assign io_offset = wb_adr[2:0];

  // Writes land on the edge that raises ack
  assign ram_we = accept && wb_we && (region == mylstar_pkg::REG_RAM);
  assign io_we  = accept && wb_we && (region == mylstar_pkg::REG_IO);
  assign pal_we = accept && wb_we && (region == mylstar_pkg::REG_PALETTE);

  always_comb begin
    wb_dat_r = '0;
    if (wb_ack) begin
      case (region_q)
        mylstar_pkg::REG_RAM: wb_dat_r = ram_rdata;
        mylstar_pkg::REG_IO:  wb_dat_r = io_rdata;
        default:              wb_dat_r = '0;
      endcase
    end
  end

  ack_single_cycle: assert property (@(posedge CLK) disable iff (!arst_n)
    wb_ack |=> !wb_ack);

  ack_follows_request: assert property (@(posedge CLK) disable iff (!arst_n)
    wb_ack |-> $past(wb_cyc && wb_stb));

endmodule

//--- verilog/mylstar_io_regs.sv
`timescale 1ns/1ns

module mylstar_io_regs (
  input  logic                CLK,
  input  logic                arst_n,
  input  logic                we,
  input  logic [2:0]          offset,
  input  mylstar_pkg::data_t  wdata,
  input  mylstar_pkg::data_t  dip_switch,
  input  mylstar_pkg::data_t  in0,
  input  mylstar_pkg::data_t  in1,
  output mylstar_pkg::data_t  rdata,
  output logic [5:0]          out_a,
  output logic [4:0]          ctrl,
  output mylstar_pkg::data_t  out_b
);

  // Output latches, upper bits of the byte dropped
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      out_a <= '0;
      ctrl  <= '0;
      out_b <= '0;
    end else if (we) begin
      case (offset)
        mylstar_pkg::IO_OUT_A:  out_a <= wdata[5:0];
        mylstar_pkg::IO_CTRL:   ctrl  <= wdata[4:0];
        mylstar_pkg::IO_PORT_B: out_b <= wdata;
        default:                ;
      endcase
    end
  end

  // Input ports, live values; write-only offsets read as zero
  always_comb begin
    case (offset)
      mylstar_pkg::IO_DIP:    rdata = dip_switch;
      mylstar_pkg::IO_IN0:    rdata = in0;
      mylstar_pkg::IO_PORT_B: rdata = in1;
      default:                rdata = '0;
    endcase
  end

endmodule

//--- verilog/mylstar_work_ram.sv
`timescale 1ns/1ns

module mylstar_work_ram (
  input  logic                                CLK,
  input  logic                                we,
  input  logic [mylstar_pkg::RAM_ADDR_W-1:0]  addr,
  input  mylstar_pkg::data_t                  wdata,
  output mylstar_pkg::data_t                  rdata
);

  localparam int DEPTH = 2 ** mylstar_pkg::RAM_ADDR_W;

  mylstar_pkg::data_t mem [DEPTH];

  // Read every cycle, old data on a write to the same address
  always_ff @(posedge CLK) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

//--- verilog/mylstar_pkg.sv
package mylstar_pkg;

  typedef logic [7:0]  data_t;
  typedef logic [15:0] adr_t;
  typedef logic [3:0]  nibble_t;

  localparam int RAM_ADDR_W = 11;

  // Window bases as Wishbone word addresses
  localparam adr_t RAM_BASE = 16'h0000;
  localparam adr_t PAL_BASE = 16'h1000;
  localparam adr_t IO_BASE  = 16'h1800;

  // Offsets inside the I/O window
  localparam logic [2:0] IO_DIP    = 3'd0;
  localparam logic [2:0] IO_IN0    = 3'd1;
  localparam logic [2:0] IO_OUT_A  = 3'd2;
  localparam logic [2:0] IO_CTRL   = 3'd3;
  localparam logic [2:0] IO_PORT_B = 3'd4;

  typedef enum logic [1:0] {
    REG_RAM,
    REG_PALETTE,
    REG_IO,
    REG_NONE
  } bus_region_e;

  typedef enum logic {
    BUS_IDLE,
    BUS_ACK
  } bus_state_e;

endpackage
